/* csa_search_top.f */
+incdir+include
hdl/csa_cfg_pkg.sv
hdl/csa_job_pkg.sv
hdl/job_admit.sv
hdl/ck_derive.sv
hdl/stream_round.sv
hdl/iter_ring.sv
hdl/csa_search_top.sv
sim/csa_search_tb.sv

/* Bender.yml */
package:
  name: csa_search

sources:
  # packages first, then the ring modules and the top level
  - files:
      - hdl/csa_cfg_pkg.sv
      - hdl/csa_job_pkg.sv
      - hdl/job_admit.sv
      - hdl/ck_derive.sv
      - hdl/stream_round.sv
      - hdl/iter_ring.sv
      - hdl/csa_search_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/csa_search_tb.sv

/* include/csa_model.svh */
`ifndef CSA_MODEL_SVH
`define CSA_MODEL_SVH

// 32 bit lcg for stall patterns
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

// passes a job makes with a floor of one
function automatic int unsigned model_passes(input csa_job_pkg::count_t times,
		input csa_job_pkg::count_t start);
	csa_job_pkg::count_t span;
	span = times - start;
	return (span == '0) ? 1 : span;
endfunction

// all sub-rounds of one pass
function automatic csa_job_pkg::word_t model_cipher(input csa_job_pkg::word_t ck);
	csa_job_pkg::word_t x;
	x = ck;
	for (int i = 0; i < csa_cfg_pkg::CIPHER_STAGES; i++) begin
		x = {x[55:0], x[63:56]} ^ csa_cfg_pkg::SB_CONST;
	end
	return x;
endfunction

// expected result of one job
function automatic csa_job_pkg::result_t csa_model(input csa_job_pkg::job_t job);
	csa_job_pkg::result_t res;
	csa_job_pkg::count_t left;
	csa_job_pkg::count_t loops;
	csa_job_pkg::word_t cb;
	csa_job_pkg::word_t ck;
	logic first;
	left = model_passes(job.times, job.start);
	cb = '0;
	first = 1'b1;
	do begin
		loops = job.times - left;
		if (first) begin
			ck = csa_job_pkg::word_t'(job.seed) ^ csa_job_pkg::word_t'(loops); // seed pass
		end else begin
			ck = cb ^ csa_job_pkg::word_t'(loops);
		end
		first = 1'b0;
		cb = model_cipher(ck);
		left = left - 1;
	end while (left != '0);
	res.tag = job.tag;
	res.seed = job.seed;
	res.times = job.times;
	res.start = job.start;
	res.result = cb;
	return res;
endfunction

`endif

/* sim/csa_search_tb.sv */
`timescale 1ns/1ns

module csa_search_tb;

	import csa_cfg_pkg::*;
	import csa_job_pkg::*;

	`include "csa_model.svh"

	localparam int N_JOBS = 28;
	localparam int WAIT_LIMIT = 3000; // cycles per phase

	logic clk;
	logic rst_n;
	logic fifo_ready_i;
	job_t fifo_job_i;
	logic fifo_ren_o;
	logic result_valid_o;
	result_t result_o;

	job_t job_tab [N_JOBS];
	result_t exp_tab [N_JOBS];
	int pop_cycle [N_JOBS];
	int retire_cnt [N_JOBS];
	int fifo_q [$]; // table indices still waiting in the FIFO
	int cycle;
	logic [31:0] lcg_state;
	logic stall_en;
	int value_errs;
	int proto_errs;
	int timeout_errs;

	csa_search_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_ready_i(fifo_ready_i),
		.fifo_job_i(fifo_job_i),
		.fifo_ren_o(fifo_ren_o),
		.result_valid_o(result_valid_o),
		.result_o(result_o)
	);

	always #20 clk = ~clk;

	function automatic job_t make_job(input tag_t tag, input seed_t seed,
			input count_t times, input count_t start);
		job_t j;
		j = '0;
		j.tag = tag;
		j.seed = seed;
		j.times = times;
		j.start = start;
		j.left = '1; // must be ignored by the DUT
		j.cb = '1;
		return j;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			value_errs++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic build_table();
		count_t start;
		job_tab[0] = make_job(32'h7A00_0000, 48'h0123_4567_89AB, 32'd40, 32'd40);
		job_tab[1] = make_job(32'h7A00_0001, 48'hFEDC_BA98_7654, 32'd12, 32'd7); // 5 passes
		job_tab[2] = make_job(32'h7A00_0002, 48'h0000_0000_0001, 32'd3, 32'd2);
		job_tab[3] = make_job(32'h7A00_0003, 48'hAAAA_5555_AAAA, 32'd3, 32'd0);
		job_tab[4] = make_job(32'h7A00_0004, 48'h1234_0000_5678, 32'd110, 32'd100);
		job_tab[5] = make_job(32'h7A00_0005, 48'hFFFF_FFFF_FFFF, 32'd9, 32'd7);
		job_tab[6] = make_job(32'h7A00_0006, 48'h8000_0000_0000, 32'd5, 32'd5);
		job_tab[7] = make_job(32'h7A00_0007, 48'h0F0F_0F0F_0F0F, 32'd27, 32'd20);
		job_tab[8] = make_job(32'h7A00_0008, 48'h3C3C_C3C3_3C3C, 32'd4, 32'd0);
		job_tab[9] = make_job(32'h7A00_0009, 48'h0000_DEAD_BEEF, 32'd1, 32'd0);
		job_tab[10] = make_job(32'h7A00_000A, 48'h7777_1111_2222, 32'd66, 32'd60);
		job_tab[11] = make_job(32'h7A00_000B, 48'h5A5A_A5A5_0000, 32'd2, 32'd0);
		job_tab[12] = make_job(32'h7A00_000C, 48'h0001_0002_0003, 32'd9, 32'd0);
		job_tab[13] = make_job(32'h7A00_000D, 48'hC0FF_EE00_1234, 32'd15, 32'd12);
		for (int i = 14; i < N_JOBS; i++) begin
			lcg_state = lcg_next(lcg_state);
			start = count_t'(lcg_state[23:16]);
			job_tab[i] = make_job(tag_t'(32'h7A00_0000 + i),
				{lcg_state, lcg_state[15:0] ^ 16'h9E37},
				start + count_t'(lcg_state[31:29]), start); // up to 7 passes
		end
		for (int i = 0; i < N_JOBS; i++) begin
			exp_tab[i] = csa_model(job_tab[i]);
			pop_cycle[i] = 0;
			retire_cnt[i] = 0;
		end
	endtask

	task automatic check_result();
		int idx;
		idx = -1;
		for (int i = 0; i < N_JOBS; i++) begin
			if (exp_tab[i].tag == result_o.tag) begin
				idx = i;
			end
		end
		assert (idx >= 0) else begin
			proto_errs++;
			$display("result carries unknown tag %h at cycle %0d", result_o.tag, cycle);
		end
		if (idx >= 0) begin
			retire_cnt[idx]++;
			assert (retire_cnt[idx] == 1) else begin
				proto_errs++;
				$display("tag %h retired more than once", result_o.tag);
			end
			check_value("result_o.seed", result_o.seed, exp_tab[idx].seed);
			check_value("result_o.times", result_o.times, exp_tab[idx].times);
			check_value("result_o.start", result_o.start, exp_tab[idx].start);
			check_value("result_o.result", result_o.result, exp_tab[idx].result);
			check_value("result latency", cycle - pop_cycle[idx],
				RING_DEPTH * model_passes(job_tab[idx].times, job_tab[idx].start) + 1);
		end
	endtask

	// drive on the falling edge and sample once inputs have settled
	task automatic run_cycle();
		@(negedge clk);
		if (stall_en) begin
			lcg_state = lcg_next(lcg_state);
		end
		if (fifo_q.size() > 0) begin
			fifo_ready_i = !(stall_en && (lcg_state[31:30] == 2'b00)); // 1 in 4 stalls
			fifo_job_i = job_tab[fifo_q[0]];
		end else begin
			fifo_ready_i = 1'b0;
			fifo_job_i = '0;
		end
		#1;
		cycle++;
		assert (!((fifo_ren_o === 1'b1) && !fifo_ready_i)) else begin
			proto_errs++;
			$display("pop requested while the FIFO was not ready at cycle %0d", cycle);
		end
		if ((fifo_ren_o === 1'b1) && (fifo_q.size() > 0)) begin
			pop_cycle[fifo_q[0]] = cycle;
			void'(fifo_q.pop_front());
		end
		if (result_valid_o === 1'b1) begin
			check_result();
		end
	endtask

	task automatic run_phase(input int first, input int count, input logic stalls);
		int waited;
		int done;
		stall_en = stalls;
		for (int i = first; i < first + count; i++) begin
			fifo_q.push_back(i);
		end
		waited = 0;
		done = 0;
		while ((done < count) && (waited < WAIT_LIMIT)) begin
			run_cycle();
			waited++;
			done = 0;
			for (int i = first; i < first + count; i++) begin
				if (retire_cnt[i] > 0) begin
					done++;
				end
			end
		end
		assert (done == count) else begin
			timeout_errs++;
			$display("timeout: only %0d of %0d jobs from entry %0d retired", done, count, first);
		end
		fifo_q.delete();
		for (int k = 0; k < 2 * RING_DEPTH; k++) begin
			run_cycle(); // late duplicates would show here
		end
		for (int i = first; i < first + count; i++) begin
			assert (retire_cnt[i] == 1) else begin
				proto_errs++;
				$display("tag %h retired %0d times", job_tab[i].tag, retire_cnt[i]);
			end
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		fifo_ready_i = 1'b1; // offered on purpose while in reset
		fifo_job_i = job_tab[0];
		for (int k = 0; k < 7; k++) begin
			@(negedge clk);
			#1;
			check_value("fifo_ren_o", fifo_ren_o, 0);
			check_value("result_valid_o", result_valid_o, 0);
		end
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		check_value("fifo_ren_o", fifo_ren_o, 0);
		check_value("result_valid_o", result_valid_o, 0);
		for (int k = 0; k < 3; k++) begin
			@(negedge clk);
			fifo_ready_i = 1'b0;
			fifo_job_i = '0;
			#1;
			check_value("fifo_ren_o", fifo_ren_o, 0);
			check_value("result_valid_o", result_valid_o, 0);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		fifo_ready_i = 1'b0;
		fifo_job_i = '0;
		stall_en = 1'b0;
		cycle = 0;
		value_errs = 0;
		proto_errs = 0;
		timeout_errs = 0;
		lcg_state = 32'd6;
		build_table();
		apply_reset();
		run_phase(0, 1, 1'b0); // single pass
		run_phase(1, 1, 1'b0); // five passes
		run_phase(2, 12, 1'b0); // back to back with more jobs than slots
		run_phase(14, 14, 1'b1);
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errs, proto_errs, timeout_errs);
		if ((value_errs + proto_errs + timeout_errs) == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* hdl/csa_search_top.sv */
`timescale 1ns/1ns

module csa_search_top (
	input logic clk,
	input logic rst_n,
	input logic fifo_ready_i,
	input csa_job_pkg::job_t fifo_job_i,
	output logic fifo_ren_o,
	output logic result_valid_o,
	output csa_job_pkg::result_t result_o
);

	import csa_job_pkg::*;

	job_t admit_job;
	job_t entry_job;
	job_t derived_job;
	word_t ck;
	word_t cb;
	logic slot_free;

	job_admit u_job_admit (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_ready_i(fifo_ready_i),
		.fifo_job_i(fifo_job_i),
		.slot_free_i(slot_free),
		.fifo_ren_o(fifo_ren_o),
		.admit_job_o(admit_job)
	);

	iter_ring u_iter_ring (
		.clk(clk),
		.rst_n(rst_n),
		.admit_job_i(admit_job),
		.derived_job_i(derived_job),
		.cb_i(cb),
		.entry_job_o(entry_job),
		.slot_free_o(slot_free),
		.result_valid_o(result_valid_o),
		.result_o(result_o)
	);

	// first ring stage
	ck_derive u_ck_derive (
		.clk(clk),
		.rst_n(rst_n),
		.job_i(entry_job),
		.job_o(derived_job),
		.ck_o(ck)
	);

	// remaining ring stages
	stream_round u_stream_round (
		.clk(clk),
		.rst_n(rst_n),
		.ck_i(ck),
		.cb_o(cb)
	);

endmodule

/* hdl/iter_ring.sv */
`timescale 1ns/1ns

module iter_ring (
	input logic clk,
	input logic rst_n,
	input csa_job_pkg::job_t admit_job_i,
	input csa_job_pkg::job_t derived_job_i,
	input csa_job_pkg::word_t cb_i,
	output csa_job_pkg::job_t entry_job_o,
	output logic slot_free_o,
	output logic result_valid_o,
	output csa_job_pkg::result_t result_o
);

	import csa_cfg_pkg::*;
	import csa_job_pkg::*;

	job_t pipe_q [CIPHER_STAGES]; // tracks the cipher pipeline
	job_t end_job;
	job_t recirc_job;
	logic retire;
	logic recirc;

	assign end_job = pipe_q[CIPHER_STAGES-1];

	// ring end decision
	assign retire = end_job.valid && (end_job.left <= count_t'(1));
	assign recirc = end_job.valid && !retire;
	assign slot_free_o = !recirc; // empty or leaving

	always_comb begin
		recirc_job = end_job;
		recirc_job.left = end_job.left - count_t'(1);
		recirc_job.cb = cb_i;
	end

	// circulating jobs keep their slot
	assign entry_job_o = recirc ? recirc_job : admit_job_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < CIPHER_STAGES; k++) begin
				pipe_q[k].valid <= 1'b0;
			end
			result_valid_o <= 1'b0;
		end else begin
			pipe_q[0] <= derived_job_i;
			for (int k = 1; k < CIPHER_STAGES; k++) begin
				pipe_q[k] <= pipe_q[k-1];
			end
			result_valid_o <= retire; // single cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			result_o <= '{
				tag: end_job.tag,
				seed: end_job.seed,
				times: end_job.times,
				start: end_job.start,
				result: cb_i
			};
		end
	end

endmodule

/* hdl/stream_round.sv */
`timescale 1ns/1ns

module stream_round (
	input logic clk,
	input logic rst_n,
	input csa_job_pkg::word_t ck_i,
	output csa_job_pkg::word_t cb_o
);

	import csa_cfg_pkg::*;
	import csa_job_pkg::*;

	word_t stage_q [CIPHER_STAGES];

	// rotate left one byte, then mix in the stream constant
	function automatic word_t sub_round(input word_t x);
		word_t rot;
		rot = {x[WORD_W-9:0], x[WORD_W-1:WORD_W-8]};
		return rot ^ SB_CONST;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < CIPHER_STAGES; k++) begin
				stage_q[k] <= '0;
			end
		end else begin
			stage_q[0] <= sub_round(ck_i);
			for (int k = 1; k < CIPHER_STAGES; k++) begin
				stage_q[k] <= sub_round(stage_q[k-1]); // one job per stage
			end
		end
	end

	assign cb_o = stage_q[CIPHER_STAGES-1];

endmodule

/* hdl/ck_derive.sv */
`timescale 1ns/1ns

module ck_derive (
	input logic clk,
	input logic rst_n,
	input csa_job_pkg::job_t job_i,
	output csa_job_pkg::job_t job_o,
	output csa_job_pkg::word_t ck_o
);

	import csa_job_pkg::*;

	count_t loops;
	logic first_pass;
	word_t ck_d;

	always_comb begin
		loops = job_i.times - job_i.left;
		// single pass jobs enter with left forced to 1
		first_pass = (loops == job_i.start) || (job_i.times == job_i.start);
		if (first_pass) begin
			ck_d = word_t'(job_i.seed) ^ word_t'(loops); // seed based
		end else begin
			ck_d = job_i.cb ^ word_t'(loops); // chain from last pass
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			job_o.valid <= 1'b0;
		end else begin
			job_o <= job_i;
		end
	end

	always_ff @(posedge clk) begin
		ck_o <= ck_d;
	end

endmodule

/* hdl/job_admit.sv */
`timescale 1ns/1ns

module job_admit (
	input logic clk,
	input logic rst_n,
	input logic fifo_ready_i,
	input csa_job_pkg::job_t fifo_job_i,
	input logic slot_free_i,
	output logic fifo_ren_o,
	output csa_job_pkg::job_t admit_job_o
);

	import csa_job_pkg::*;

	logic run_q;
	count_t span;

	// admission opens one cycle after reset is released
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
		end
	end

	assign span = fifo_job_i.times - fifo_job_i.start;

	// fwft fifo pops in the cycle the job is taken
	assign fifo_ren_o = run_q && fifo_ready_i && slot_free_i;

	always_comb begin
		admit_job_o = '0; // empty slot
		if (fifo_ren_o) begin
			admit_job_o = fifo_job_i;
			admit_job_o.valid = 1'b1;
			admit_job_o.left = (span == '0) ? count_t'(1) : span; // at least one pass
			admit_job_o.cb = '0;
		end
	end

endmodule

/* hdl/csa_job_pkg.sv */
package csa_job_pkg;

	import csa_cfg_pkg::*;

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SEED_W-1:0] seed_t;
	typedef logic [WORD_W-1:0] word_t;

	// one ring slot
	typedef struct packed {
		logic valid; // slot occupied
		tag_t tag;
		seed_t seed;
		count_t times;
		count_t start;
		count_t left; // passes still to run, current one included
		word_t cb; // last cipher word
	} job_t;

	// retired job
	typedef struct packed {
		tag_t tag;
		seed_t seed;
		count_t times;
		count_t start;
		word_t result;
	} result_t;

endpackage

/* hdl/csa_cfg_pkg.sv */
package csa_cfg_pkg;

	// field widths
	localparam int COUNT_W = 32; // times, start and left
	localparam int TAG_W = 32;
	localparam int SEED_W = 48;
	localparam int WORD_W = 64; // control word and cipher word

	// ring timing
	localparam int RING_DEPTH = 8; // cycles per pass
	localparam int CIPHER_STAGES = RING_DEPTH - 1; // key stage takes the other cycle

	// fixed stream constant fed to every sub-round
	localparam logic [WORD_W-1:0] SB_CONST = 64'hE613_DB6D_C11C_4524;

endpackage
